// ==== src/uartPkg.sv ====
package uartPkg;

    // Bus widths of the AXI4-Lite register port
    localparam int addrWidth = 4;
    localparam int busWidth = 32;

    // Register offsets
    localparam logic [addrWidth-1:0] addrTxData = 4'h0;
    localparam logic [addrWidth-1:0] addrRxData = 4'h4;
    localparam logic [addrWidth-1:0] addrStatus = 4'h8;
    localparam logic [addrWidth-1:0] addrBaudDiv = 4'hC;

    // Bit positions in the status word
    localparam int stTxReady = 0;
    localparam int stRxValid = 1;
    localparam int stOverrun = 2;
    localparam int stFrameErr = 3;

    // AXI response codes
    localparam logic [1:0] respOkay = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // Baud divisor register
    localparam int divWidth = 16;
    localparam logic [divWidth-1:0] resetBaudDiv = '0;

endpackage

// ==== src/uartCtrlIf.sv ====
`timescale 1ns/1ps

interface uartCtrlIf #(
    parameter int dataWidth = 8
);

    // Transmit side
    logic [dataWidth-1:0] txData;
    logic txStart;
    logic txReady;

    // Receive holding register and its flags
    logic [dataWidth-1:0] rxData;
    logic rxValid;
    logic rxOverrun;
    logic rxFrameErr;
    logic rxClear;

    modport decoder (
        output txData, txStart, rxClear,
        input txReady, rxData, rxValid, rxOverrun, rxFrameErr
    );

    modport transmitter (
        input txData, txStart,
        output txReady
    );

    modport result (
        input rxClear,
        output rxData, rxValid, rxOverrun, rxFrameErr
    );

endinterface

// ==== src/uartRegDecode.sv ====
`timescale 1ns/1ps

module uartRegDecode #(
    parameter int dataWidth = 8
) (
    input logic clk,
    input logic rstN,
    input logic [uartPkg::addrWidth-1:0] awaddr,
    input logic awvalid,
    output logic awready,
    input logic [uartPkg::busWidth-1:0] wdata,
    input logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input logic [uartPkg::addrWidth-1:0] araddr,
    input logic arvalid,
    output logic arready,
    output logic [uartPkg::busWidth-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input logic rready,
    uartCtrlIf.decoder ctrl,
    output logic [uartPkg::divWidth-1:0] baudDiv
);

    import uartPkg::*;

    logic wrHs;
    logic arHs;
    logic wrOk;
    logic rdOk;
    logic [busWidth-1:0] statusWord;
    logic [busWidth-1:0] readWord;

    // Address and data are taken together, so one cycle finishes the write
    assign awready = awvalid && wvalid && !bvalid;
    assign wready = awready;
    assign wrHs = awready;

    assign arready = !rvalid;
    assign arHs = arvalid && arready;

    always_comb begin
        case (awaddr)
            addrTxData: wrOk = ctrl.txReady;
            addrBaudDiv: wrOk = 1'b1;
            default: wrOk = 1'b0;
        endcase
    end

    // A busy transmitter drops the byte instead of starting
    assign ctrl.txStart = wrHs && (awaddr == addrTxData) && ctrl.txReady;
    assign ctrl.txData = wdata[dataWidth-1:0];
    assign ctrl.rxClear = arHs && (araddr == addrRxData);

    always_comb begin
        statusWord = '0;
        statusWord[stTxReady] = ctrl.txReady;
        statusWord[stRxValid] = ctrl.rxValid;
        statusWord[stOverrun] = ctrl.rxOverrun;
        statusWord[stFrameErr] = ctrl.rxFrameErr;
    end

    always_comb begin
        readWord = '0;
        rdOk = 1'b1;
        case (araddr)
            addrRxData: readWord = busWidth'(ctrl.rxData);
            addrStatus: readWord = statusWord;
            addrBaudDiv: readWord = busWidth'(baudDiv);
            default: rdOk = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bvalid <= 1'b0;
            baudDiv <= resetBaudDiv;
        end else begin
            if (wrHs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wrHs && (awaddr == addrBaudDiv)) begin
                baudDiv <= wdata[divWidth-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrHs) begin
            bresp <= wrOk ? respOkay : respSlvErr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rvalid <= 1'b0;
        end else if (arHs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arHs) begin
            rdata <= readWord;
            rresp <= rdOk ? respOkay : respSlvErr;
        end
    end

    // Responses may not be withdrawn before the host accepts them
    bHoldA: assert property (@(posedge clk) disable iff (!rstN)
        bvalid && !bready |=> bvalid);
    rHoldA: assert property (@(posedge clk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== src/uartBaudGen.sv ====
`timescale 1ns/1ps

module uartBaudGen (
    input logic clk,
    input logic rstN,
    input logic [uartPkg::divWidth-1:0] baudDiv,
    output logic baudTick
);

    import uartPkg::*;

    logic [divWidth-1:0] count;

    // The divisor is only loaded at zero, so a new value waits for the next reload
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            baudTick <= 1'b0;
        end else if (count == '0) begin
            count <= baudDiv;
            baudTick <= 1'b1;
        end else begin
            count <= count - 1'b1;
            baudTick <= 1'b0;
        end
    end

endmodule

// ==== src/uartTransmitter.sv ====
`timescale 1ns/1ps

module uartTransmitter #(
    parameter int dataWidth = 8
) (
    input logic clk,
    input logic rstN,
    input logic baudTick,
    uartCtrlIf.transmitter ctrl,
    output logic txd
);

    typedef enum logic [1:0] {
        txIdle,
        txStartBit,
        txDataBits,
        txStopBit
    } txState;

    localparam int countWidth = $clog2(dataWidth);

    txState state;
    txState stateNext;
    logic [dataWidth-1:0] shiftReg;
    logic [dataWidth-1:0] shiftNext;
    logic [countWidth-1:0] bitCount;
    logic [countWidth-1:0] bitCountNext;
    logic [3:0] tickCount;
    logic [3:0] tickNext;
    logic txBit;
    logic txBitNext;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= txIdle;
            bitCount <= '0;
            tickCount <= '0;
            txBit <= 1'b1;
        end else begin
            state <= stateNext;
            bitCount <= bitCountNext;
            tickCount <= tickNext;
            txBit <= txBitNext;
        end
    end

    always_ff @(posedge clk) begin
        shiftReg <= shiftNext;
    end

    always_comb begin
        stateNext = state;
        shiftNext = shiftReg;
        bitCountNext = bitCount;
        tickNext = tickCount;
        txBitNext = txBit;
        case (state)
            txIdle: begin
                txBitNext = 1'b1;
                if (ctrl.txStart) begin
                    shiftNext = ctrl.txData;
                    tickNext = '0;
                    txBitNext = 1'b0;
                    stateNext = txStartBit;
                end
            end
            txStartBit: begin
                if (baudTick) begin
                    tickNext = tickCount + 1'b1;
                    if (tickCount == 4'd15) begin
                        bitCountNext = '0;
                        txBitNext = shiftReg[0];
                        stateNext = txDataBits;
                    end
                end
            end
            txDataBits: begin
                txBitNext = shiftReg[0];
                if (baudTick) begin
                    tickNext = tickCount + 1'b1;
                    if (tickCount == 4'd15) begin
                        shiftNext = shiftReg >> 1;
                        bitCountNext = bitCount + 1'b1;
                        txBitNext = shiftNext[0];
                        if (bitCount == countWidth'(dataWidth - 1)) begin
                            txBitNext = 1'b1;
                            stateNext = txStopBit;
                        end
                    end
                end
            end
            txStopBit: begin
                if (baudTick) begin
                    tickNext = tickCount + 1'b1;
                    if (tickCount == 4'd15) begin
                        stateNext = txIdle;
                    end
                end
            end
            default: stateNext = txIdle;
        endcase
    end

    assign txd = txBit;
    assign ctrl.txReady = (state == txIdle);

    // A start request puts the start bit on the line one clock later
    startBitA: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.txStart |=> !ctrl.txReady && !txd);

endmodule

// ==== src/uartReceiver.sv ====
`timescale 1ns/1ps

module uartReceiver #(
    parameter int dataWidth = 8
) (
    input logic clk,
    input logic rstN,
    input logic baudTick,
    input logic rxd,
    output logic [dataWidth-1:0] rxByte,
    output logic rxDone,
    output logic rxBadStop
);

    typedef enum logic [1:0] {
        rxIdle,
        rxStartBit,
        rxDataBits,
        rxStopBit
    } rxState;

    localparam int countWidth = $clog2(dataWidth);

    rxState state;
    logic [1:0] rxSync;
    logic rxLine;
    logic rxPrev;
    logic [3:0] tickCount;
    logic [countWidth-1:0] bitCount;

    // Two flops against metastability on the asynchronous pin
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxSync <= 2'b11;
            rxPrev <= 1'b1;
        end else begin
            rxSync <= {rxSync[0], rxd};
            rxPrev <= rxLine;
        end
    end

    assign rxLine = rxSync[1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= rxIdle;
            tickCount <= '0;
            bitCount <= '0;
            rxDone <= 1'b0;
            rxBadStop <= 1'b0;
        end else begin
            rxDone <= 1'b0;
            case (state)
                rxIdle: begin
                    if (rxPrev && !rxLine) begin
                        tickCount <= '0;
                        state <= rxStartBit;
                    end
                end
                rxStartBit: begin
                    if (baudTick) begin
                        tickCount <= tickCount + 1'b1;
                        // Mid-point of the start bit, a high line here was a glitch
                        if (tickCount == 4'd7) begin
                            tickCount <= '0;
                            bitCount <= '0;
                            state <= rxLine ? rxIdle : rxDataBits;
                        end
                    end
                end
                rxDataBits: begin
                    if (baudTick) begin
                        tickCount <= tickCount + 1'b1;
                        if (tickCount == 4'd15) begin
                            bitCount <= bitCount + 1'b1;
                            if (bitCount == countWidth'(dataWidth - 1)) begin
                                state <= rxStopBit;
                            end
                        end
                    end
                end
                rxStopBit: begin
                    if (baudTick) begin
                        tickCount <= tickCount + 1'b1;
                        if (tickCount == 4'd15) begin
                            rxDone <= 1'b1;
                            rxBadStop <= !rxLine;
                            state <= rxIdle;
                        end
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    // LSB arrives first and ends up in bit 0
    always_ff @(posedge clk) begin
        if (state == rxDataBits && baudTick && tickCount == 4'd15) begin
            rxByte <= {rxLine, rxByte[dataWidth-1:1]};
        end
    end

endmodule

// ==== src/uartRxResult.sv ====
`timescale 1ns/1ps

module uartRxResult #(
    parameter int dataWidth = 8
) (
    input logic clk,
    input logic rstN,
    input logic [dataWidth-1:0] rxByte,
    input logic rxDone,
    input logic rxBadStop,
    uartCtrlIf.result ctrl
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl.rxValid <= 1'b0;
            ctrl.rxOverrun <= 1'b0;
            ctrl.rxFrameErr <= 1'b0;
        end else if (rxDone) begin
            ctrl.rxValid <= 1'b1;
            // A byte read in this same cycle was consumed, so it is no overrun
            ctrl.rxOverrun <= (ctrl.rxOverrun || ctrl.rxValid) && !ctrl.rxClear;
            ctrl.rxFrameErr <= rxBadStop;
        end else if (ctrl.rxClear) begin
            ctrl.rxValid <= 1'b0;
            ctrl.rxOverrun <= 1'b0;
            ctrl.rxFrameErr <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rxDone) begin
            ctrl.rxData <= rxByte;
        end
    end

    // Error flags only ever describe a byte that is still held
    flagsNeedValidA: assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.rxOverrun || ctrl.rxFrameErr) |-> ctrl.rxValid);

endmodule

// ==== src/uartTop.sv ====
`timescale 1ns/1ps

module uartTop #(
    parameter int dataWidth = 8
) (
    input logic clk,
    input logic rstN,
    input logic [uartPkg::addrWidth-1:0] awaddr,
    input logic awvalid,
    output logic awready,
    input logic [uartPkg::busWidth-1:0] wdata,
    input logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input logic [uartPkg::addrWidth-1:0] araddr,
    input logic arvalid,
    output logic arready,
    output logic [uartPkg::busWidth-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input logic rready,
    output logic txd,
    input logic rxd
);

    import uartPkg::*;

    logic [divWidth-1:0] baudDiv;
    logic baudTick;
    logic [dataWidth-1:0] rxByte;
    logic rxDone;
    logic rxBadStop;

    uartCtrlIf #(.dataWidth(dataWidth)) ctrl ();

    uartRegDecode #(.dataWidth(dataWidth)) regDecode (
        .clk(clk), .rstN(rstN),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .ctrl(ctrl.decoder), .baudDiv(baudDiv)
    );

    uartBaudGen baudGen (
        .clk(clk), .rstN(rstN), .baudDiv(baudDiv), .baudTick(baudTick)
    );

    uartTransmitter #(.dataWidth(dataWidth)) transmitter (
        .clk(clk), .rstN(rstN), .baudTick(baudTick),
        .ctrl(ctrl.transmitter), .txd(txd)
    );

    uartReceiver #(.dataWidth(dataWidth)) receiver (
        .clk(clk), .rstN(rstN), .baudTick(baudTick), .rxd(rxd),
        .rxByte(rxByte), .rxDone(rxDone), .rxBadStop(rxBadStop)
    );

    uartRxResult #(.dataWidth(dataWidth)) rxResult (
        .clk(clk), .rstN(rstN), .rxByte(rxByte), .rxDone(rxDone),
        .rxBadStop(rxBadStop), .ctrl(ctrl.result)
    );

endmodule

// ==== tb/uartTb.sv ====
`timescale 1ns/1ps

module uartTb;

    import uartPkg::*;

    localparam int dataWidth = 8;
    localparam int tbDiv = 1;
    localparam int loopFrames = 8;
    localparam int bitClocks = 16 * (tbDiv + 1);
    // Loopback frames plus busy, two overrun and one frame error frame, doubled
    localparam int watchdogClocks = (loopFrames + 4) * (dataWidth + 2) * bitClocks * 2;
    localparam logic [addrWidth-1:0] addrUnmapped = 4'h6;

    typedef struct packed {
        logic [busWidth-1:0] rxData;
        logic [busWidth-1:0] status;
    } frameResult;

    logic clk;
    logic rstN;
    logic [addrWidth-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [busWidth-1:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [addrWidth-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [busWidth-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic txd;
    logic rxd;
    logic lineLow;
    logic [addrWidth-1:0] lastAraddr;
    int seed;
    int errorCount;
    frameResult expectedRx[$];

    uartTop #(.dataWidth(dataWidth)) uut (
        .clk(clk), .rstN(rstN),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .txd(txd), .rxd(rxd)
    );

    // Loopback, lineLow pulls the line down to corrupt a frame
    assign rxd = txd && !lineLow;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic failRun(input string reason);
        errorCount++;
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [busWidth-1:0] actual,
                              input logic [busWidth-1:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    // Received byte and status word after one frame, read once the transmitter is idle
    function automatic frameResult expectedFrame(input logic [dataWidth-1:0] sent,
                                                 input logic stopLow, input logic heldValid);
        frameResult res;
        res.rxData = busWidth'(sent);
        res.status = '0;
        res.status[stTxReady] = 1'b1;
        res.status[stRxValid] = 1'b1;
        res.status[stOverrun] = heldValid;
        res.status[stFrameErr] = stopLow;
        return res;
    endfunction

    // Rising edges on the line up to the stop bit, the top data bit must be zero
    function automatic int stopRiseCount(input logic [dataWidth-1:0] sent);
        int count;
        logic prev;
        count = 0;
        prev = 1'b0;
        for (int i = 0; i < dataWidth; i++) begin
            if (!prev && sent[i]) begin
                count++;
            end
            prev = sent[i];
        end
        return count + 1;
    endfunction

    function automatic logic [dataWidth-1:0] randomByte();
        int word;
        word = $random(seed);
        return word[dataWidth-1:0];
    endfunction

    task automatic axiWrite(input logic [addrWidth-1:0] addr, input logic [busWidth-1:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        checkValue("wready", busWidth'(wready), busWidth'(1'b1));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [addrWidth-1:0] addr, output logic [busWidth-1:0] data,
                           output logic [1:0] resp);
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic waitStatusBit(input int bitPos);
        logic [busWidth-1:0] word;
        logic [1:0] resp;
        word = '0;
        while (!word[bitPos]) begin
            axiRead(addrStatus, word, resp);
        end
    endtask

    // Transmitter idle again, and the frame has landed in the holding register
    task automatic waitFrameDone();
        waitStatusBit(stTxReady);
        waitStatusBit(stRxValid);
    endtask

    task automatic sendByte(input logic [dataWidth-1:0] sent);
        logic [1:0] resp;
        axiWrite(addrTxData, busWidth'(sent), resp);
        checkValue("bresp", busWidth'(resp), busWidth'(respOkay));
    endtask

    task automatic checkReceived(input logic [dataWidth-1:0] sent, input logic stopLow,
                                 input logic heldValid);
        frameResult want;
        logic [busWidth-1:0] word;
        logic [1:0] resp;
        want = expectedFrame(sent, stopLow, heldValid);
        axiRead(addrStatus, word, resp);
        checkValue("status", word, want.status);
        expectedRx.push_back(want);
        axiRead(addrRxData, word, resp);
        axiRead(addrStatus, word, resp);
        checkValue("status", word, busWidth'(1) << stTxReady);
    endtask

    // Every RXDATA read is compared against the oldest expected frame
    always @(posedge clk) begin
        frameResult want;
        if (arvalid && arready) begin
            lastAraddr <= araddr;
        end
        if (rvalid && rready && lastAraddr == addrRxData) begin
            if (expectedRx.size() == 0) begin
                failRun("RXDATA was read while no received byte was expected");
            end else begin
                want = expectedRx.pop_front();
                checkValue("rdata", rdata, want.rxData);
                checkValue("rresp", busWidth'(rresp), busWidth'(respOkay));
            end
        end
    end

    initial begin
        repeat (watchdogClocks) @(posedge clk);
        failRun($sformatf("timeout: the tests did not finish within %0d clocks",
                          watchdogClocks));
    end

    initial begin
        logic [busWidth-1:0] word;
        logic [1:0] resp;
        logic [dataWidth-1:0] first;
        logic [dataWidth-1:0] second;
        int rises;
        seed = 17265;
        errorCount = 0;
        rstN = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        lineLow = 1'b0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;

        axiRead(addrStatus, word, resp);
        checkValue("status", word, busWidth'(1) << stTxReady);
        axiRead(addrBaudDiv, word, resp);
        checkValue("baudDiv", word, busWidth'(resetBaudDiv));
        axiWrite(addrBaudDiv, busWidth'(tbDiv), resp);
        checkValue("bresp", busWidth'(resp), busWidth'(respOkay));
        axiRead(addrBaudDiv, word, resp);
        checkValue("baudDiv", word, busWidth'(tbDiv));

        for (int i = 0; i < loopFrames; i++) begin
            first = randomByte();
            sendByte(first);
            waitFrameDone();
            checkReceived(first, 1'b0, 1'b0);
        end

        // A second byte while the line is busy must be refused
        first = randomByte();
        second = randomByte();
        sendByte(first);
        axiRead(addrStatus, word, resp);
        checkValue("status.txReady", busWidth'(word[stTxReady]), '0);
        axiWrite(addrTxData, busWidth'(second), resp);
        checkValue("bresp", busWidth'(resp), busWidth'(respSlvErr));
        waitFrameDone();
        checkReceived(first, 1'b0, 1'b0);

        first = randomByte();
        second = randomByte();
        sendByte(first);
        waitFrameDone();
        sendByte(second);
        waitFrameDone();
        checkReceived(second, 1'b0, 1'b1);

        // Hold the line low for the whole stop bit
        first = randomByte();
        first[dataWidth-1] = 1'b0;
        rises = stopRiseCount(first);
        sendByte(first);
        repeat (rises) @(posedge txd);
        @(negedge clk);
        lineLow = 1'b1;
        repeat (bitClocks) @(negedge clk);
        lineLow = 1'b0;
        waitFrameDone();
        checkReceived(first, 1'b1, 1'b0);

        axiRead(addrUnmapped, word, resp);
        checkValue("rdata", word, '0);
        checkValue("rresp", busWidth'(resp), busWidth'(respSlvErr));
        axiWrite(addrStatus, '1, resp);
        checkValue("bresp", busWidth'(resp), busWidth'(respSlvErr));
        checkValue("pending RXDATA checks", busWidth'(expectedRx.size()), '0);

        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/uartPkg.sv
src/uartCtrlIf.sv
src/uartRegDecode.sv
src/uartBaudGen.sv
src/uartTransmitter.sv
src/uartReceiver.sv
src/uartRxResult.sv
src/uartTop.sv
tb/uartTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module uartTb -f src.f -o uartSim \
    && ./obj_dir/uartSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0
